// ==== src/scratchpad_pkg.sv ====
/*
  Width constants and request/response words shared by the scratchpad RTL.
  Depth must stay a power of two so every address maps to a word.
*/

`default_nettype none

package scratchpad_pkg;

  // Memory geometry
  localparam int data_width    = 8;
  localparam int memory_depth  = 16;
  localparam int address_width = $clog2(memory_depth);

  // One client request, as carried by req and by the RAM port
  typedef struct packed {
    logic                     write;
    logic [address_width-1:0] address;
    logic [data_width-1:0]    write_data;
  } scratch_request_t;

  // Returned with ack
  // Holds the last read value after a write
  typedef struct packed {
    logic [data_width-1:0] read_data;
  } scratch_response_t;

endpackage

`default_nettype wire

// ==== src/true_dual_port_ram.sv ====
/*
  Two read-write ports on one clock, no reset on the array.
  Same-address writes in one cycle keep port 1's data.
  READ_LATENCY 1 gives read-first registered reads, held while idle.
  READ_LATENCY 0 reads the array combinationally.
*/

`timescale 1ns/100ps
`default_nettype none

module true_dual_port_ram
  import scratchpad_pkg::*;
#(
  parameter int READ_LATENCY = 1
) (
  input  wire logic                  port_0_clock,
  // First port
  input  wire logic                  port_0_access_enable,
  input  wire scratch_request_t      port_0_request,
  output logic      [data_width-1:0] port_0_read_data,
  // Second port
  input  wire logic                  port_1_access_enable,
  input  wire scratch_request_t      port_1_request,
  output logic      [data_width-1:0] port_1_read_data
);

  // Storage
  logic [data_width-1:0] memory [memory_depth];

  // Write strobes from the request's write flag
  logic port_0_write_enable;
  logic port_1_write_enable;

  assign port_0_write_enable = port_0_access_enable & port_0_request.write;
  assign port_1_write_enable = port_1_access_enable & port_1_request.write;

  // Both writes in one block
  // Port 1 comes last so it wins a same-address collision
  always_ff @(posedge port_0_clock) begin
    if (port_0_write_enable) begin
      memory[port_0_request.address] <= port_0_request.write_data;
    end
    if (port_1_write_enable) begin
      memory[port_1_request.address] <= port_1_request.write_data;
    end
  end

  if (READ_LATENCY != 0) begin : registered_read
    logic port_0_read_enable;
    logic port_1_read_enable;

    assign port_0_read_enable = port_0_access_enable & ~port_0_request.write;
    assign port_1_read_enable = port_1_access_enable & ~port_1_request.write;

    // Samples the array before this edge's writes land, so read-first
    always_ff @(posedge port_0_clock) begin
      if (port_0_read_enable) begin
        port_0_read_data <= memory[port_0_request.address];
      end
      if (port_1_read_enable) begin
        port_1_read_data <= memory[port_1_request.address];
      end
    end
  end else begin : combinational_read
    // Straight from the array at the current address
    assign port_0_read_data = memory[port_0_request.address];
    assign port_1_read_data = memory[port_1_request.address];
  end

endmodule

`default_nettype wire

// ==== src/access_port_controller.sv ====
/*
  Turns one four-phase req/ack handshake into one RAM access.
  Client must hold request stable while req is high.
  Ack stays high until req is seen low; no new access before that.
  Response updates only on reads.
*/

`timescale 1ns/100ps
`default_nettype none

module access_port_controller
  import scratchpad_pkg::*;
#(
  parameter int READ_LATENCY = 1
) (
  input  wire logic                  port_0_clock,
  input  wire logic                  rst,
  // Client side
  input  wire logic                  req,
  input  wire scratch_request_t      request,
  output logic                       ack,
  output scratch_response_t          response,
  // RAM side
  output logic                       access_enable,
  output scratch_request_t           ram_request,
  input  wire logic [data_width-1:0] read_data
);

  typedef enum logic [1:0] {
    state_idle,
    state_access,
    state_wait,
    state_acknowledge
  } state_t;

  state_t           state;
  scratch_request_t held_request;
  logic             capture;

  // Read data is valid one cycle after access for latency 1,
  // during access itself for latency 0
  assign capture = (state == state_wait) ||
                   ((state == state_access) && (READ_LATENCY == 0));

  // Handshake sequencing
  always_ff @(posedge port_0_clock) begin
    if (rst) begin
      state <= state_idle;
    end else begin
      case (state)
        state_idle: begin
          if (req) begin
            state <= state_access;
          end
        end
        state_access: begin
          // Skip the wait state when reads are combinational
          state <= (READ_LATENCY == 0) ? state_acknowledge : state_wait;
        end
        state_wait: begin
          state <= state_acknowledge;
        end
        state_acknowledge: begin
          // Hold until the client drops req
          if (!req) begin
            state <= state_idle;
          end
        end
        default: state <= state_idle;
      endcase
    end
  end

  // Latch the request on acceptance
  always_ff @(posedge port_0_clock) begin
    if ((state == state_idle) && req) begin
      held_request <= request;
    end
  end

  // Ack and response registers
  always_ff @(posedge port_0_clock) begin
    if (rst) begin
      ack      <= 1'b0;
      response <= '0;
    end else begin
      if (capture) begin
        ack <= 1'b1;
        if (!held_request.write) begin
          response.read_data <= read_data;
        end
      end else if ((state == state_acknowledge) && !req) begin
        ack <= 1'b0;
      end
    end
  end

  // Exactly one cycle of RAM activity per handshake
  assign access_enable = (state == state_access);
  assign ram_request   = held_request;

endmodule

`default_nettype wire

// ==== src/shared_scratchpad.sv ====
/*
  Two client ports sharing one dual-port scratchpad on a single clock.
  Ports are independent except for same-cycle collisions:
  port 1 wins a write-write, a read racing a write sees the old data.
*/

`timescale 1ns/100ps
`default_nettype none

module shared_scratchpad
  import scratchpad_pkg::*;
#(
  parameter int READ_LATENCY = 1
) (
  input  wire logic              port_0_clock,
  input  wire logic              rst,
  // Client 0
  input  wire logic              port_0_req,
  input  wire scratch_request_t  port_0_request,
  output logic                   port_0_ack,
  output scratch_response_t      port_0_response,
  // Client 1
  input  wire logic              port_1_req,
  input  wire scratch_request_t  port_1_request,
  output logic                   port_1_ack,
  output scratch_response_t      port_1_response
);

  // Controller to RAM links
  logic                  port_0_access_enable;
  logic                  port_1_access_enable;
  scratch_request_t      port_0_ram_request;
  scratch_request_t      port_1_ram_request;
  logic [data_width-1:0] port_0_read_data;
  logic [data_width-1:0] port_1_read_data;

  access_port_controller #(.READ_LATENCY(READ_LATENCY)) port_0_controller (
    .port_0_clock  (port_0_clock),
    .rst           (rst),
    .req           (port_0_req),
    .request       (port_0_request),
    .ack           (port_0_ack),
    .response      (port_0_response),
    .access_enable (port_0_access_enable),
    .ram_request   (port_0_ram_request),
    .read_data     (port_0_read_data)
  );

  access_port_controller #(.READ_LATENCY(READ_LATENCY)) port_1_controller (
    .port_0_clock  (port_0_clock),
    .rst           (rst),
    .req           (port_1_req),
    .request       (port_1_request),
    .ack           (port_1_ack),
    .response      (port_1_response),
    .access_enable (port_1_access_enable),
    .ram_request   (port_1_ram_request),
    .read_data     (port_1_read_data)
  );

  // Shared storage
  true_dual_port_ram #(.READ_LATENCY(READ_LATENCY)) memory (
    .port_0_clock         (port_0_clock),
    .port_0_access_enable (port_0_access_enable),
    .port_0_request       (port_0_ram_request),
    .port_0_read_data     (port_0_read_data),
    .port_1_access_enable (port_1_access_enable),
    .port_1_request       (port_1_ram_request),
    .port_1_read_data     (port_1_read_data)
  );

endmodule

`default_nettype wire

// ==== test/access_port_chk.sv ====
/*
  Handshake rules of one access port controller, bound to every instance.
  Checks are off while rst is high, except the post-reset ack check.
*/

`timescale 1ns/100ps
`default_nettype none

module access_port_chk (
  input wire logic port_0_clock,
  input wire logic rst,
  input wire logic req,
  input wire logic ack,
  input wire logic access_enable
);

  // Failed properties so far
  int failure_count = 0;

  // Ack goes high only for a pending request
  ack_rises_with_req: assert property (
    @(posedge port_0_clock) disable iff (rst) $rose(ack) |-> $past(req)
  ) else begin
    $error("ack rose while req was low");
    failure_count++;
  end

  // Ack drops only once the client has released req
  ack_falls_after_req: assert property (
    @(posedge port_0_clock) disable iff (rst) $fell(ack) |-> !$past(req)
  ) else begin
    $error("ack fell while req was still high");
    failure_count++;
  end

  // One RAM access per handshake
  access_single_cycle: assert property (
    @(posedge port_0_clock) disable iff (rst) access_enable |=> !access_enable
  ) else begin
    $error("access_enable stayed high for more than one cycle");
    failure_count++;
  end

  // Access only inside the request phase
  access_in_request: assert property (
    @(posedge port_0_clock) disable iff (rst) access_enable |-> (req && !ack)
  ) else begin
    $error("access_enable outside a pending request");
    failure_count++;
  end

  // Reset clears ack
  ack_low_after_reset: assert property (
    @(posedge port_0_clock) rst |=> !ack
  ) else begin
    $error("ack not low in the cycle after reset");
    failure_count++;
  end

endmodule

`default_nettype wire

// ==== test/shared_scratchpad_tb.sv ====
/*
  Drives both clients through four-phase handshakes at READ_LATENCY 1.
  Expected data comes from a shadow memory, updated in port order at each ack rise.
  Every address is written before it is first read.
*/

`timescale 1ns/100ps
`default_nettype none

module shared_scratchpad_tb
  import scratchpad_pkg::*;
();

  // Run bound, from handshake count and longest handshake with gap and hold
  localparam int handshake_limit        = 130;
  localparam int worst_handshake_cycles = 30;
  localparam int timeout_cycles         = handshake_limit * worst_handshake_cycles + 200;

  logic              port_0_clock = 1'b0;
  logic              rst;
  logic [1:0]        req;
  scratch_request_t  request [2];
  wire  [1:0]        ack;
  scratch_response_t response [2];

  // Reference state
  logic [data_width-1:0] shadow [memory_depth];
  logic [data_width-1:0] last_read [2];
  logic [1:0]            ack_seen;
  logic [15:0]           lfsr_state = 16'd60675;

  int error_count     = 0;
  int compare_count   = 0;
  int handshake_count = 0;
  int cycle_count     = 0;

  shared_scratchpad #(.READ_LATENCY(1)) UUT (
    .port_0_clock    (port_0_clock),
    .rst             (rst),
    .port_0_req      (req[0]),
    .port_0_request  (request[0]),
    .port_0_ack      (ack[0]),
    .port_0_response (response[0]),
    .port_1_req      (req[1]),
    .port_1_request  (request[1]),
    .port_1_ack      (ack[1]),
    .port_1_response (response[1])
  );

  bind access_port_controller access_port_chk handshake_rules (
    .port_0_clock  (port_0_clock),
    .rst           (rst),
    .req           (req),
    .ack           (ack),
    .access_enable (access_enable)
  );

  always #2 port_0_clock = ~port_0_clock;

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [31:0] random_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = {lfsr_state[14:0],
                    lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
      value = {value[30:0], lfsr_state[0]};
    end
    return value;
  endfunction

  function automatic logic random_flag();
    logic [31:0] value;
    value = random_bits(1);
    return value[0];
  endfunction

  function automatic logic [data_width-1:0] random_data();
    logic [31:0] value;
    value = random_bits(data_width);
    return value[data_width-1:0];
  endfunction

  // Upper address bit picks the half
  function automatic logic [address_width-1:0] random_address_in(input logic upper_half);
    logic [31:0] value;
    value = random_bits(address_width - 1);
    return {upper_half, value[address_width-2:0]};
  endfunction

  // Expected response at an ack rise
  // Writes keep the last read value; reads see memory before same-cycle writes
  function automatic logic [data_width-1:0] reference_response(input logic port);
    if (request[port].write) begin
      return last_read[port];
    end
    return shadow[request[port].address];
  endfunction

  task automatic compare_on_rise(input logic port);
    logic [data_width-1:0] expected;
    if (ack[port] && !ack_seen[port]) begin
      expected = reference_response(port);
      compare_count++;
      if (response[port].read_data !== expected) begin
        $display("mismatch port_%0d_response.read_data: expected %h, got %h",
                 port, expected, response[port].read_data);
        error_count++;
      end
      if (!request[port].write) begin
        last_read[port] = expected;
      end
    end
  endtask

  task automatic commit_on_rise(input logic port);
    if (ack[port] && !ack_seen[port] && request[port].write) begin
      shadow[request[port].address] = request[port].write_data;
    end
  endtask

  // Comparison at every ack rise, sampled mid-cycle
  always @(negedge port_0_clock) begin
    if (!rst) begin
      compare_on_rise(1'b0);
      compare_on_rise(1'b1);
      // Port 1 last, so it wins a same-cycle write to one address
      commit_on_rise(1'b0);
      commit_on_rise(1'b1);
    end
    ack_seen = ack;
  end

  // One full four-phase handshake on one port, with timing checks
  task automatic run_handshake(input logic port, input logic is_write,
                               input logic [address_width-1:0] address,
                               input logic [data_width-1:0] data, input int hold,
                               output logic [data_width-1:0] result);
    scratch_request_t  word;
    scratch_response_t held;
    int                edges;
    word.write      = is_write;
    word.address    = address;
    word.write_data = data;
    @(posedge port_0_clock);
    request[port] <= word;
    req[port]     <= 1'b1;
    edges = 0;
    do begin
      @(negedge port_0_clock);
      edges++;
    end while (!ack[port]);
    handshake_count++;
    // One negedge before the edge that samples req and one right after it
    if (edges - 2 != 2) begin
      $display("port %0d ack rose %0d edges after req was sampled, expected 2",
               port, edges - 2);
      error_count++;
    end
    held = response[port];
    repeat (hold) begin
      @(negedge port_0_clock);
      if (!ack[port]) begin
        $display("port %0d ack dropped while req was still held", port);
        error_count++;
      end
      if (response[port] !== held) begin
        $display("mismatch port_%0d_response: expected %h, got %h",
                 port, held, response[port]);
        error_count++;
      end
    end
    @(posedge port_0_clock);
    req[port] <= 1'b0;
    edges = 0;
    do begin
      @(negedge port_0_clock);
      edges++;
    end while (ack[port]);
    if (edges != 2) begin
      $display("port %0d ack fell %0d edges after req was lowered, expected 2",
               port, edges);
      error_count++;
    end
    result = held.read_data;
  endtask

  task automatic finish_run();
    int assertion_failures;
    assertion_failures = UUT.port_0_controller.handshake_rules.failure_count +
                         UUT.port_1_controller.handshake_rules.failure_count;
    error_count += assertion_failures;
    $display("handshakes: %0d, compares: %0d, assertion failures: %0d, errors: %0d",
             handshake_count, compare_count, assertion_failures, error_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  endtask

  always @(posedge port_0_clock) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout: run did not finish within %0d cycles", timeout_cycles);
      error_count++;
      finish_run();
    end
  end

  initial begin
    logic [address_width-1:0] address;
    logic [data_width-1:0]    data;
    logic [data_width-1:0]    result_0;
    logic [data_width-1:0]    result_1;
    rst          = 1'b1;
    req          = 2'b00;
    request[0]   = '0;
    request[1]   = '0;
    ack_seen     = 2'b00;
    last_read[0] = '0;
    last_read[1] = '0;
    repeat (5) @(posedge port_0_clock);
    rst <= 1'b0;

    // Reset state
    @(negedge port_0_clock);
    if (ack !== 2'b00) begin
      $display("mismatch ack: expected 0, got %h", ack);
      error_count++;
    end
    if (response[0] !== '0) begin
      $display("mismatch port_0_response: expected 00, got %h", response[0]);
      error_count++;
    end
    if (response[1] !== '0) begin
      $display("mismatch port_1_response: expected 00, got %h", response[1]);
      error_count++;
    end

    // Port 0 fills every address, then reads all back
    for (int i = 0; i < memory_depth; i++) begin
      run_handshake(1'b0, 1'b1, i[address_width-1:0], random_data(), 0, result_0);
    end
    for (int i = 0; i < memory_depth; i++) begin
      run_handshake(1'b0, 1'b0, i[address_width-1:0], '0, 0, result_0);
    end

    // Cross-port visibility in both directions
    for (int i = 0; i < 8; i++) begin
      address = random_address_in(random_flag());
      run_handshake(1'b1, 1'b1, address, random_data(), 0, result_1);
      run_handshake(1'b0, 1'b0, address, '0, 0, result_0);
      address = random_address_in(random_flag());
      run_handshake(1'b0, 1'b1, address, random_data(), 0, result_0);
      run_handshake(1'b1, 1'b0, address, '0, 0, result_1);
    end

    // Concurrent traffic on disjoint halves with random gaps
    fork
      for (int i = 0; i < 24; i++) begin
        repeat (random_bits(3)) @(posedge port_0_clock);
        run_handshake(1'b0, random_flag(), random_address_in(1'b0), random_data(),
                      random_bits(2), result_0);
      end
      for (int i = 0; i < 24; i++) begin
        repeat (random_bits(3)) @(posedge port_0_clock);
        run_handshake(1'b1, random_flag(), random_address_in(1'b1), random_data(),
                      random_bits(2), result_1);
      end
    join

    // Same-cycle writes to one address keep port 1's data
    address = random_address_in(random_flag());
    data    = random_data();
    fork
      run_handshake(1'b0, 1'b1, address, data, 0, result_0);
      run_handshake(1'b1, 1'b1, address, ~data, 0, result_1);
    join
    run_handshake(1'b0, 1'b0, address, '0, 0, result_0);
    if (result_0 !== ~data) begin
      $display("mismatch port_0_response.read_data: expected %h, got %h", ~data, result_0);
      error_count++;
    end

    // Read racing a write returns the old word
    address = random_address_in(random_flag());
    data    = random_data();
    run_handshake(1'b1, 1'b1, address, data, 0, result_1);
    fork
      run_handshake(1'b0, 1'b0, address, '0, 0, result_0);
      run_handshake(1'b1, 1'b1, address, ~data, 0, result_1);
    join
    if (result_0 !== data) begin
      $display("mismatch port_0_response.read_data: expected %h, got %h", data, result_0);
      error_count++;
    end

    // Back-pressure with req held for a random time
    for (int i = 0; i < 4; i++) begin
      run_handshake(i[0], random_flag(), random_address_in(random_flag()), random_data(),
                    int'(random_bits(4)) + 1, result_0);
    end

    if (compare_count != handshake_count) begin
      $display("comparison process saw %0d ack rises for %0d handshakes",
               compare_count, handshake_count);
      error_count++;
    end
    finish_run();
  end

endmodule

`default_nettype wire

// ==== shared_scratchpad.f ====
src/scratchpad_pkg.sv
src/true_dual_port_ram.sv
src/access_port_controller.sv
src/shared_scratchpad.sv
test/access_port_chk.sv
test/shared_scratchpad_tb.sv

// ==== Makefile ====
# Verilator build and run of the scratchpad testbench

VERILATOR ?= verilator
TOP       ?= shared_scratchpad_tb
FILE_LIST ?= shared_scratchpad.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= NO ERRORS
VFLAGS    ?= --binary --timing --assert

# Sources are read from the file list, skipping option lines
SOURCES := $(shell grep -v '^+' $(FILE_LIST))
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BINARY): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

# Pass only when the log holds the pass line
run: $(BINARY)
	$(BINARY) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
